/* list.f */
+incdir+verilog
verilog/sparcDecodePkg.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/branchResolver.sv
verilog/decodeStage.sv
bench/decodeStage_checker.sv
bench/decodeStageTb.sv

/* bench/decodeStageTb.sv */
`timescale 1ns/1ns
`include "sparcDecode_params.svh"

module decodeStageTb
    import sparcDecodePkg::*;
();

    localparam int resetCycles   = 10;
    localparam int numAluTests   = 40;
    localparam int plannedCycles = (2 * `NUM_REGS + 2) + (numAluTests + 2) + (8 + 4 + 2)
                                 + (16 * 2 * 2 + 2) + (7 + 2) + (4 + 2);
    localparam int timeoutCycles = 2 * plannedCycles + resetCycles;

    // Load/store op3 codes with their store, signed and size columns
    localparam logic [5:0] memOp3 [8] = '{6'b001001, 6'b001010, 6'b000000, 6'b000001,
                                          6'b000010, 6'b000101, 6'b000110, 6'b000100};
    localparam logic memStore [8] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    localparam logic memSigned [8] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    localparam memSizeT memSz [8] = '{memByte, memHalf, memWord, memByte,
                                      memHalf, memByte, memHalf, memWord};
    // Low op3 nibble to ALU op with shifts at 5 to 7 when op3[5] is set
    localparam aluOpT aluMap [16] = '{aluAdd, aluAnd, aluOr, aluXor, aluSub, aluAndn, aluOrn,
                                      aluXnor, aluAddx, aluAdd, aluAdd, aluAdd, aluSubx,
                                      aluAdd, aluAdd, aluAdd};
    localparam aluOpT shiftMap [3] = '{aluSll, aluSrl, aluSra};
    localparam logic [3:0] aluNibble [10] = '{4'd0, 4'd8, 4'd4, 4'd12, 4'd1,
                                              4'd2, 4'd3, 4'd5, 4'd6, 4'd7};

    logic                   Clk = 1'b0;
    logic                   rstN;
    logic                   instrValid;
    instrWordT              instr;
    logic                   bubble;
    logic                   wbEnable;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`WORD_W-1:0]     wbData;
    logic                   ccWrite;
    iccT                    ccFlags;
    logic                   exValid;
    exBundleT               exBundle;
    logic                   branchTaken;
    logic                   annul;

    logic [`WORD_W-1:0] shadowRegs [`NUM_REGS];
    iccT                shadowIcc;
    exBundleT           expBundle;
    logic               expValid;
    logic               expTaken;
    logic               expAnnul;
    logic               pendingValid = 1'b0;
    logic [31:0]        rnd;
    int                 errorCount = 0;
    int                 checkCount = 0;
    int                 testCount = 0;
    int                 testBase = 0;
    int                 cycleCount = 0;

    decodeStage dut (.*);

    always #20 Clk = ~Clk;

    always @(posedge Clk)
    begin
        cycleCount++;
        if (cycleCount > timeoutCycles)
        begin
            $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic condMet(input logic [3:0] cond, input iccT f);
        logic r;
        case (cond)
            4'b1000: r = 1'b1;
            4'b0000: r = 1'b0;
            4'b1001: r = !f.z;
            4'b0001: r = f.z;
            4'b1010: r = !(f.z || (f.n ^ f.v));
            4'b0010: r = f.z || (f.n ^ f.v);
            4'b1011: r = !(f.n ^ f.v);
            4'b0011: r = f.n ^ f.v;
            4'b1100: r = !(f.c || f.z);
            4'b0100: r = f.c || f.z;
            4'b1101: r = !f.c;
            4'b0101: r = f.c;
            4'b1110: r = !f.n;
            4'b0110: r = f.n;
            4'b1111: r = !f.v;
            default: r = f.v;
        endcase
        return r;
    endfunction

    function automatic void refDecode(input instrWordT w, input logic valid, input logic bub,
                                      input logic [`WORD_W-1:0] regs [`NUM_REGS],
                                      input iccT f, output exBundleT exp,
                                      output logic taken, output logic ann);
        ctrlBundleT             c;
        logic [`WORD_W-1:0]     immVal;
        logic [`REG_ADDR_W-1:0] rdSel;
        logic [3:0]             nib;
        c      = '0;
        nib    = w.fmt3.op3[3:0];
        rdSel  = (w.fmt1.op == 2'b01) ? 5'd15 : w.fmt3.rd;   // CALL links to o7
        immVal = {{19{w.fmt3.simm13[12]}}, w.fmt3.simm13};
        case (w.fmt1.op)
            2'b00:
            begin
                if (w.fmt2.op2 == 3'b100)
                begin
                    c.rfWrite = 1'b1;
                    c.aluOp   = aluPassB;
                    immVal    = {w.fmt2.imm22, 10'b0};
                end
                else
                begin
                    c.branch   = (w != '0);   // All-zero word is NOP
                    c.annulBit = w.fmt2.annul;
                    immVal     = {{10{w.fmt2.imm22[21]}}, w.fmt2.imm22};
                end
            end
            2'b01:
            begin
                c.call    = 1'b1;
                c.rfWrite = 1'b1;
                immVal    = {w.fmt1.disp30, 2'b00};
            end
            2'b10:
            begin
                c.rfWrite = 1'b1;
                c.jmpl    = (w.fmt3.op3 == 6'b111000);
                if (!c.jmpl)
                begin
                    c.modifyCC = w.fmt3.op3[4];
                    c.aluOp = (w.fmt3.op3[5] && nib >= 5 && nib <= 7) ? shiftMap[nib - 5]
                                                                      : aluMap[nib];
                end
            end
            default:
            begin
                c.memEnable = 1'b1;
                for (int k = 0; k < 8; k++)
                begin
                    if (w.fmt3.op3 == memOp3[k])
                    begin
                        c.memWrite = memStore[k];
                        c.load     = !memStore[k];
                        c.signExt  = memSigned[k];
                        c.memSize  = memSz[k];
                    end
                end
                c.rfWrite = c.load;
            end
        endcase
        if (!valid || bub)
            c = '0;
        exp.ctrl      = c;
        exp.operandA  = regs[w.fmt3.rs1];
        exp.operandB  = (w.fmt1.op == 2'b00 || (w.fmt3.op[1] && w.fmt3.i)) ? immVal
                                                                            : regs[w[4:0]];
        exp.storeData = regs[rdSel];
        exp.rd        = rdSel;
        exp.imm       = immVal;
        taken         = c.branch && condMet(w.fmt2.cond, f);
        ann           = c.branch && c.annulBit && !taken;
    endfunction

    task automatic reportMismatch(input string name, input logic [`WORD_W-1:0] exp,
                                  input logic [`WORD_W-1:0] act);
        $display("FAIL %s exp %h got %h at %0t", name, exp, act, $time);
        errorCount++;
    endtask

    task automatic checkFlagBit(input string name, input logic exp, input logic act);
        checkCount++;
        if (exp !== act)
            reportMismatch(name, {31'b0, exp}, {31'b0, act});
    endtask

    task automatic checkCtrl(input ctrlBundleT exp, input ctrlBundleT act);
        checkCount++;
        if (exp !== act)
            reportMismatch("exBundle.ctrl", {16'b0, exp}, {16'b0, act});
    endtask

    task automatic checkBundle(input exBundleT exp, input exBundleT act);
        checkCtrl(exp.ctrl, act.ctrl);
        checkCount++;
        if (exp.operandA !== act.operandA)
            reportMismatch("exBundle.operandA", exp.operandA, act.operandA);
        if (exp.operandB !== act.operandB)
            reportMismatch("exBundle.operandB", exp.operandB, act.operandB);
        if (exp.storeData !== act.storeData)
            reportMismatch("exBundle.storeData", exp.storeData, act.storeData);
        if (exp.rd !== act.rd)
            reportMismatch("exBundle.rd", {27'b0, exp.rd}, {27'b0, act.rd});
        if (exp.imm !== act.imm)
            reportMismatch("exBundle.imm", exp.imm, act.imm);
    endtask

    // Mid-cycle compare of the last edge, then predict the next one and apply writes
    always @(negedge Clk)
    begin
        iccT effFlags;
        if (!rstN)
        begin
            pendingValid = 1'b0;
            shadowIcc    = '0;
        end
        else
        begin
            if (pendingValid)
            begin
                checkFlagBit("exValid", expValid, exValid);
                checkBundle(expBundle, exBundle);
                checkFlagBit("branchTaken", expTaken, branchTaken);
                checkFlagBit("annul", expAnnul, annul);
            end
            effFlags = ccWrite ? ccFlags : shadowIcc;   // Flag bypass
            refDecode(instr, instrValid, bubble, shadowRegs, effFlags,
                      expBundle, expTaken, expAnnul);
            expValid     = instrValid;
            pendingValid = 1'b1;
            if (wbEnable && wbAddr != '0)
                shadowRegs[wbAddr] = wbData;
            if (ccWrite)
                shadowIcc = ccFlags;
        end
    end

    function automatic instrWordT makeFmt3(input logic [1:0] op, input logic [4:0] rd,
                                           input logic [5:0] op3, input logic [4:0] rs1,
                                           input logic i, input logic [12:0] low13);
        instrWordT w;
        w.fmt3 = '{op, rd, op3, rs1, i, low13};
        return w;
    endfunction

    function automatic instrWordT makeBranch(input logic a, input logic [3:0] cond,
                                             input logic [21:0] disp);
        instrWordT w;
        w.fmt2 = '{2'b00, a, cond, 3'b010, disp};   // Bicc
        return w;
    endfunction

    task automatic stepInstr(input instrWordT w, input logic valid, input logic bub);
        @(posedge Clk);
        #5;
        instr      = w;
        instrValid = valid;
        bubble     = bub;
        wbEnable   = 1'b0;
        ccWrite    = 1'b0;
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [`WORD_W-1:0] data);
        stepInstr('0, 1'b0, 1'b0);
        wbEnable = 1'b1;
        wbAddr   = addr;
        wbData   = data;
    endtask

    task automatic flagCycle(input instrWordT w, input logic valid, input iccT f);
        stepInstr(w, valid, 1'b0);
        ccWrite = 1'b1;
        ccFlags = f;
    endtask

    task automatic finishTest(input string name);
        stepInstr('0, 1'b0, 1'b0);
        @(posedge Clk);   // Last instruction checked by now
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errorCount - testBase);
        testBase = errorCount;
    endtask

    initial
    begin
        instrWordT  w;
        logic [5:0] op3;
        int         idx;
        void'($urandom(32'h535f));
        rstN       = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        bubble     = 1'b0;
        wbEnable   = 1'b0;
        wbAddr     = '0;
        wbData     = '0;
        ccWrite    = 1'b0;
        ccFlags    = '0;
        for (int r = 0; r < `NUM_REGS; r++)
            shadowRegs[r] = 'x;   // Unwritten registers read X
        shadowRegs[0] = '0;
        #2;
        rstN = 1'b0;   // Clean falling edge
        repeat (resetCycles) @(posedge Clk);
        #5;
        checkFlagBit("exValid", 1'b0, exValid);
        checkBundle('0, exBundle);
        checkFlagBit("branchTaken", 1'b0, branchTaken);
        checkFlagBit("annul", 1'b0, annul);
        rstN = 1'b1;

        for (int r = 0; r < `NUM_REGS; r++)
        begin
            rnd = $urandom;
            writeReg(5'(r), rnd);   // R0 write must be dropped
        end
        for (int r = 0; r < `NUM_REGS; r++)
            stepInstr(makeFmt3(2'b10, 5'(r), 6'b000000, 5'(r), 1'b0, 13'((r + 7) % 32)),
                      1'b1, 1'b0);
        finishTest("reset and writeback");

        for (int k = 0; k < numAluTests; k++)
        begin
            rnd = $urandom;
            idx = int'(rnd[31:26]) % 10;
            op3 = {rnd[1:0], aluNibble[idx]};
            if (op3 == 6'b111000)
                op3[4] = 1'b0;   // Keep clear of JMPL
            stepInstr(makeFmt3(2'b10, rnd[6:2], op3, rnd[11:7], rnd[12], rnd[25:13]),
                      1'b1, 1'b0);
        end
        finishTest("alu op and immediate");

        for (int k = 0; k < 8; k++)
        begin
            rnd = $urandom;
            stepInstr(makeFmt3(2'b11, rnd[4:0], memOp3[k], rnd[9:5], rnd[10], rnd[23:11]),
                      1'b1, 1'b0);
        end
        rnd = $urandom;
        w.fmt1 = '{2'b01, rnd[29:0]};
        stepInstr(w, 1'b1, 1'b0);
        stepInstr(makeFmt3(2'b10, rnd[4:0], 6'b111000, rnd[9:5], 1'b1, rnd[22:10]), 1'b1, 1'b0);
        w.fmt2 = '{2'b00, rnd[0], rnd[4:1], 3'b100, rnd[31:10]};   // SETHI
        stepInstr(w, 1'b1, 1'b0);
        stepInstr('0, 1'b1, 1'b0);
        finishTest("other formats");

        for (int c = 0; c < 16; c++)
        begin
            for (int s = 0; s < 2; s++)
            begin
                rnd = $urandom;
                flagCycle('0, 1'b0, iccT'(rnd[3:0]));
                stepInstr(makeBranch(rnd[4], 4'(c), rnd[26:5]), 1'b1, 1'b0);
            end
        end
        finishTest("branch conditions");

        flagCycle('0, 1'b0, iccT'(4'b0000));
        flagCycle(makeBranch(1'b0, 4'b0001, 22'd16), 1'b1, iccT'(4'b0100));   // be sees new Z
        stepInstr(makeBranch(1'b0, 4'b0001, 22'd16), 1'b1, 1'b0);
        flagCycle(makeBranch(1'b1, 4'b1001, 22'd8), 1'b1, iccT'(4'b0000));
        stepInstr(makeBranch(1'b1, 4'b0000, 22'd4), 1'b1, 1'b0);   // bn,a squashes
        stepInstr(makeBranch(1'b1, 4'b1000, 22'd4), 1'b1, 1'b0);
        stepInstr(makeBranch(1'b1, 4'b0001, 22'd4), 1'b1, 1'b0);
        finishTest("flag bypass and annul");

        stepInstr(makeBranch(1'b1, 4'b1000, 22'd4), 1'b1, 1'b1);
        stepInstr(makeFmt3(2'b10, 5'd3, 6'b010000, 5'd4, 1'b1, 13'd100), 1'b1, 1'b1);
        stepInstr(makeBranch(1'b1, 4'b0000, 22'd4), 1'b0, 1'b0);
        stepInstr(makeFmt3(2'b11, 5'd5, 6'b000100, 5'd6, 1'b0, 13'd7), 1'b0, 1'b0);
        finishTest("bubble");

        $display("Summary: %0d tests, %0d checks, %0d check errors, %0d assertion failures",
                 testCount, checkCount, errorCount, dut.assertions.failCount);
        if (errorCount == 0 && dut.assertions.failCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* bench/decodeStage_checker.sv */
`timescale 1ns/1ns

module decodeStage_checker
    import sparcDecodePkg::*;
(
    input logic     Clk,
    input logic     rstN,
    input logic     bubble,
    input logic     exValid,
    input exBundleT exBundle,
    input logic     branchTaken,
    input logic     annul
);

    int failCount = 0;   // Assertion failures so far

    resetZero: assert property (@(posedge Clk)
        !rstN |-> (!exValid && (exBundle == '0) && !branchTaken && !annul))
        else
        begin
            $error("registered outputs not zero while in reset");
            failCount++;
        end

    // Squash only on a fall-through of an annulled branch in the output register
    annulNotTaken: assert property (@(posedge Clk) disable iff (!rstN)
        annul |-> (!branchTaken && exBundle.ctrl.branch && exBundle.ctrl.annulBit))
        else
        begin
            $error("annul raised without an annulled, untaken branch");
            failCount++;
        end

    bubbleEmpty: assert property (@(posedge Clk) disable iff (!rstN)
        bubble |=> (exBundle.ctrl == '0))
        else
        begin
            $error("control bundle not empty after a bubble");
            failCount++;
        end

endmodule

bind decodeStage decodeStage_checker assertions (.*);

/* verilog/decodeStage.sv */
`timescale 1ns/1ns
`include "sparcDecode_params.svh"

module decodeStage
    import sparcDecodePkg::*;
(
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  instrWordT              instr,
    input  logic                   bubble,
    input  logic                   wbEnable,
    input  logic [`REG_ADDR_W-1:0] wbAddr,
    input  logic [`WORD_W-1:0]     wbData,
    input  logic                   ccWrite,
    input  iccT                    ccFlags,
    output logic                   exValid,
    output exBundleT               exBundle,
    output logic                   branchTaken,
    output logic                   annul
);

    ctrlBundleT             rawCtrl;
    ctrlBundleT             gatedCtrl;
    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic [`WORD_W-1:0]     imm;
    logic [`WORD_W-1:0]     rs1Data;
    logic [`WORD_W-1:0]     rs2Data;
    logic [`WORD_W-1:0]     rdData;
    logic                   useImm;
    logic [`WORD_W-1:0]     operandB;
    logic                   taken;
    logic                   annulReq;
    exBundleT               nextBundle;

    instrDecoder decoder
    (
        .instr   (instr),
        .ctrl    (rawCtrl),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (rdAddr),
        .imm     (imm)
    );

    registerFile regFile
    (
        .Clk      (Clk),
        .wbEnable (wbEnable),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .rs1Addr  (rs1Addr),
        .rs2Addr  (rs2Addr),
        .rdAddr   (rdAddr),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .rdData   (rdData)
    );

    // Empty slot when stalled or nothing fetched
    assign gatedCtrl = (bubble || !instrValid) ? ctrlBundleT'(`CTRL_NOP) : rawCtrl;

    branchResolver resolver
    (
        .Clk      (Clk),
        .rstN     (rstN),
        .branch   (gatedCtrl.branch),
        .annulBit (gatedCtrl.annulBit),
        .cond     (instr.fmt2.cond),
        .ccWrite  (ccWrite),
        .ccFlags  (ccFlags),
        .taken    (taken),
        .annulReq (annulReq)
    );

    // Format 2, or format 3 with the i bit
    assign useImm   = (instr.fmt2.op == 2'b00) || (instr.fmt3.op[1] && instr.fmt3.i);
    assign operandB = useImm ? imm : rs2Data;

    always_comb
    begin
        nextBundle.ctrl      = gatedCtrl;
        nextBundle.operandA  = rs1Data;
        nextBundle.operandB  = operandB;
        nextBundle.storeData = rdData;   // Read through the rd port
        nextBundle.rd        = rdAddr;
        nextBundle.imm       = imm;
    end

    // ID/EX register
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            exValid     <= 1'b0;
            exBundle    <= '0;
            branchTaken <= 1'b0;
            annul       <= 1'b0;
        end
        else
        begin
            exValid     <= instrValid;
            exBundle    <= nextBundle;
            branchTaken <= taken;
            annul       <= annulReq;   // IF/ID squash request
        end
    end

endmodule

/* verilog/branchResolver.sv */
`timescale 1ns/1ns
`include "sparcDecode_params.svh"

module branchResolver
    import sparcDecodePkg::*;
#(
    parameter iccT iccResetVal = iccT'(`ICC_RST_VAL)
)
(
    input  logic               Clk,
    input  logic               rstN,
    input  logic               branch,
    input  logic               annulBit,
    input  logic [`COND_W-1:0] cond,
    input  logic               ccWrite,
    input  iccT                ccFlags,
    output logic               taken,
    output logic               annulReq
);

    iccT  iccReg;
    iccT  flags;
    logic condTrue;

    // PSR icc field
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            iccReg <= iccResetVal;
        else if (ccWrite)
            iccReg <= ccFlags;
    end

    assign flags = ccWrite ? ccFlags : iccReg;   // Bypass the update in flight

    // Lower half of the table, cond[3] inverts it
    always_comb
    begin
        case (cond[2:0])
            3'b000:  condTrue = 1'b0;                         // bn
            3'b001:  condTrue = flags.z;                      // be
            3'b010:  condTrue = flags.z | (flags.n ^ flags.v);   // ble
            3'b011:  condTrue = flags.n ^ flags.v;            // bl
            3'b100:  condTrue = flags.c | flags.z;            // bleu
            3'b101:  condTrue = flags.c;                      // bcs
            3'b110:  condTrue = flags.n;                      // bneg
            default: condTrue = flags.v;                      // bvs
        endcase
        if (cond[3])
            condTrue = !condTrue;
    end

    assign taken = branch & condTrue;

    // Annulled branch that falls through squashes its delay slot
    assign annulReq = branch & annulBit & ~taken;

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ns
`include "sparcDecode_params.svh"

module registerFile
(
    input  logic                   Clk,
    input  logic                   wbEnable,
    input  logic [`REG_ADDR_W-1:0] wbAddr,
    input  logic [`WORD_W-1:0]     wbData,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`REG_ADDR_W-1:0] rdAddr,
    output logic [`WORD_W-1:0]     rs1Data,
    output logic [`WORD_W-1:0]     rs2Data,
    output logic [`WORD_W-1:0]     rdData
);

    logic [`WORD_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge Clk)
    begin
        if (wbEnable && (wbAddr != '0))
            regs[wbAddr] <= wbData;
    end

    // R0 is hardwired and never stored
    // No write-through; a same-cycle read sees the old word
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];
    assign rdData  = (rdAddr == '0) ? '0 : regs[rdAddr];

endmodule

/* verilog/instrDecoder.sv */
`timescale 1ns/1ns
`include "sparcDecode_params.svh"

module instrDecoder
    import sparcDecodePkg::*;
(
    input  instrWordT              instr,
    output ctrlBundleT             ctrl,
    output logic [`REG_ADDR_W-1:0] rs1Addr,
    output logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`REG_ADDR_W-1:0] rdAddr,
    output logic [`WORD_W-1:0]     imm
);

    localparam logic [1:0] opBranch = 2'b00;
    localparam logic [1:0] opCall   = 2'b01;
    localparam logic [1:0] opArith  = 2'b10;
    localparam logic [1:0] opMem    = 2'b11;

    localparam logic [2:0] op2Sethi = 3'b100;

    localparam logic [`OP3_W-1:0] op3Jmpl = 6'b111000;
    localparam logic [`OP3_W-1:0] op3Ldsb = 6'b001001;
    localparam logic [`OP3_W-1:0] op3Ldsh = 6'b001010;
    localparam logic [`OP3_W-1:0] op3Ld   = 6'b000000;
    localparam logic [`OP3_W-1:0] op3Ldub = 6'b000001;
    localparam logic [`OP3_W-1:0] op3Lduh = 6'b000010;
    localparam logic [`OP3_W-1:0] op3Stb  = 6'b000101;
    localparam logic [`OP3_W-1:0] op3Sth  = 6'b000110;
    localparam logic [`OP3_W-1:0] op3St   = 6'b000100;

    localparam logic [`REG_ADDR_W-1:0] linkReg = 5'd15;   // CALL writes o7

    // Bit 5 of op3 picks shifts over the negated logic ops
    function automatic aluOpT mapAluOp(input logic [`OP3_W-1:0] op3);
        aluOpT sel;
        case (op3[3:0])
            4'd0:    sel = aluAdd;
            4'd8:    sel = aluAddx;
            4'd4:    sel = aluSub;
            4'd12:   sel = aluSubx;
            4'd1:    sel = aluAnd;
            4'd2:    sel = aluOr;
            4'd3:    sel = aluXor;
            4'd5:    sel = op3[5] ? aluSll : aluAndn;
            4'd6:    sel = op3[5] ? aluSrl : aluOrn;
            4'd7:    sel = op3[5] ? aluSra : aluXnor;
            default: sel = aluAdd;
        endcase
        return sel;
    endfunction

    always_comb
    begin
        ctrl = '0;
        case (instr.fmt1.op)
            opCall:
            begin
                ctrl.call    = 1'b1;
                ctrl.rfWrite = 1'b1;   // Return address
            end
            opBranch:
            begin
                if (instr == '0)
                begin
                    ctrl = '0;   // NOP
                end
                else if (instr.fmt2.op2 != op2Sethi)
                begin
                    ctrl.branch   = 1'b1;
                    ctrl.annulBit = instr.fmt2.annul;
                end
                else
                begin
                    ctrl.rfWrite = 1'b1;
                    ctrl.aluOp   = aluPassB;   // imm22 goes straight through
                end
            end
            opArith:
            begin
                ctrl.rfWrite = 1'b1;
                if (instr.fmt3.op3 == op3Jmpl)
                begin
                    ctrl.jmpl = 1'b1;
                end
                else
                begin
                    ctrl.modifyCC = instr.fmt3.op3[4];   // The cc forms
                    ctrl.aluOp    = mapAluOp(instr.fmt3.op3);
                end
            end
            opMem:
            begin
                ctrl.memEnable = 1'b1;
                case (instr.fmt3.op3)
                    op3Ldsb: {ctrl.load, ctrl.signExt, ctrl.memSize} = {2'b11, memByte};
                    op3Ldsh: {ctrl.load, ctrl.signExt, ctrl.memSize} = {2'b11, memHalf};
                    op3Ld:   {ctrl.load, ctrl.signExt, ctrl.memSize} = {2'b10, memWord};
                    op3Ldub: {ctrl.load, ctrl.signExt, ctrl.memSize} = {2'b10, memByte};
                    op3Lduh: {ctrl.load, ctrl.signExt, ctrl.memSize} = {2'b10, memHalf};
                    op3Stb:  {ctrl.memWrite, ctrl.memSize} = {1'b1, memByte};
                    op3Sth:  {ctrl.memWrite, ctrl.memSize} = {1'b1, memHalf};
                    op3St:   {ctrl.memWrite, ctrl.memSize} = {1'b1, memWord};
                    default: ctrl.memSize = memByte;   // Unknown op3, no access
                endcase
                ctrl.rfWrite = ctrl.load;   // Loads only
            end
            default: ctrl = '0;
        endcase
    end

    assign rs1Addr = instr.fmt3.rs1;
    assign rs2Addr = instr.fmt3.simm13[`REG_ADDR_W-1:0];
    assign rdAddr  = (instr.fmt1.op == opCall) ? linkReg : instr.fmt3.rd;   // Also store data

    always_comb
    begin
        if (instr.fmt3.op[1])
            imm = {{(`WORD_W-`SIMM13_W){instr.fmt3.simm13[`SIMM13_W-1]}}, instr.fmt3.simm13};
        else if (instr.fmt1.op == opCall)
            imm = {instr.fmt1.disp30, {(`WORD_W-`DISP30_W){1'b0}}};   // Word displacement
        else if (instr.fmt2.op2 == op2Sethi)
            imm = {instr.fmt2.imm22, {(`WORD_W-`IMM22_W){1'b0}}};     // Upper 22 bits
        else
            imm = {{(`WORD_W-`IMM22_W){instr.fmt2.imm22[`IMM22_W-1]}}, instr.fmt2.imm22};
    end

endmodule

/* verilog/sparcDecodePkg.sv */
`include "sparcDecode_params.svh"

package sparcDecodePkg;

    // CALL
    typedef struct packed {
        logic [1:0]           op;
        logic [`DISP30_W-1:0] disp30;
    } fmt1T;

    // Bicc and SETHI; for SETHI the annul and cond bits carry rd
    typedef struct packed {
        logic [1:0]          op;
        logic                annul;
        logic [`COND_W-1:0]  cond;
        logic [2:0]          op2;
        logic [`IMM22_W-1:0] imm22;
    } fmt2T;

    // Arithmetic, JMPL and load/store
    typedef struct packed {
        logic [1:0]             op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OP3_W-1:0]      op3;
        logic [`REG_ADDR_W-1:0] rs1;
        logic                   i;
        logic [`SIMM13_W-1:0]   simm13;   // rs2 in the low bits when i is clear
    } fmt3T;

    typedef union packed {
        fmt1T fmt1;
        fmt2T fmt2;
        fmt3T fmt3;
    } instrWordT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluAddx  = 4'd1,
        aluSub   = 4'd2,
        aluSubx  = 4'd3,
        aluAnd   = 4'd4,
        aluOr    = 4'd5,
        aluXor   = 4'd6,
        aluXnor  = 4'd7,
        aluAndn  = 4'd8,
        aluOrn   = 4'd9,
        aluSll   = 4'd10,
        aluSrl   = 4'd11,
        aluSra   = 4'd12,
        aluPassB = 4'd14
    } aluOpT;

    typedef enum logic [1:0] {
        memByte = 2'd0,
        memHalf = 2'd1,
        memWord = 2'd2
    } memSizeT;

    typedef struct packed {
        logic    jmpl;
        logic    memWrite;    // Store when set
        aluOpT   aluOp;
        logic    signExt;
        logic    load;
        logic    rfWrite;
        memSizeT memSize;
        logic    modifyCC;
        logic    call;
        logic    branch;
        logic    annulBit;
        logic    memEnable;
    } ctrlBundleT;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } iccT;

    typedef struct packed {
        ctrlBundleT             ctrl;
        logic [`WORD_W-1:0]     operandA;
        logic [`WORD_W-1:0]     operandB;
        logic [`WORD_W-1:0]     storeData;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`WORD_W-1:0]     imm;
    } exBundleT;

endpackage

/* verilog/sparcDecode_params.svh */
`ifndef SPARC_DECODE_PARAMS_SVH
`define SPARC_DECODE_PARAMS_SVH

// Datapath
`define WORD_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Instruction fields
`define SIMM13_W    13
`define IMM22_W     22
`define DISP30_W    30
`define COND_W      4
`define OP3_W       6

// Reset and idle values
`define ICC_RST_VAL 4'b0000
`define CTRL_NOP    16'h0000

`endif
